// ==== verilog/vic_pkg.sv ====
`default_nettype none

package vic_pkg;

   localparam int NUM_SPRITES = 8;

   // Chip revisions
   localparam logic [1:0] CHIP6567R8   = 2'd0;
   localparam logic [1:0] CHIP6569     = 2'd1;
   localparam logic [1:0] CHIP6567R56A = 2'd2;

   // Cycle types, L = low phi half, H = high phi half
   localparam logic [3:0] VIC_LP   = 4'd0;
   localparam logic [3:0] VIC_HS1  = 4'd1;
   localparam logic [3:0] VIC_LS2  = 4'd2;
   localparam logic [3:0] VIC_HS3  = 4'd3;
   localparam logic [3:0] VIC_HPI1 = 4'd4;
   localparam logic [3:0] VIC_LPI2 = 4'd5;
   localparam logic [3:0] VIC_HPI3 = 4'd6;
   localparam logic [3:0] VIC_LR   = 4'd7;
   localparam logic [3:0] VIC_HRI  = 4'd8;
   localparam logic [3:0] VIC_HRC  = 4'd9;
   localparam logic [3:0] VIC_HRX  = 4'd10;
   localparam logic [3:0] VIC_LG   = 4'd11;
   localparam logic [3:0] VIC_HGC  = 4'd12;
   localparam logic [3:0] VIC_HGI  = 4'd13;
   localparam logic [3:0] VIC_LI   = 4'd14;
   localparam logic [3:0] VIC_HI   = 4'd15;

   // Access kinds
   localparam logic [2:0] ACC_P = 3'd0;
   localparam logic [2:0] ACC_S = 3'd1;
   localparam logic [2:0] ACC_R = 3'd2;
   localparam logic [2:0] ACC_C = 3'd3;
   localparam logic [2:0] ACC_G = 3'd4;
   localparam logic [2:0] ACC_I = 3'd5;

   localparam int PHASE_TICKS = 4;

   localparam logic [6:0] CYCLES_6569 = 7'd63;
   localparam logic [6:0] CYCLES_R56A = 7'd64;
   localparam logic [6:0] CYCLES_R8   = 7'd65;

   localparam logic [8:0] LINES_6569 = 9'd312;
   localparam logic [8:0] LINES_R56A = 9'd262;
   localparam logic [8:0] LINES_R8   = 9'd263;

   // Sprite 3 fetch starts the line on every revision
   localparam logic [6:0] RESET_CYCLE_6569 = 7'd0;
   localparam logic [6:0] RESET_CYCLE_R56A = 7'd0;
   localparam logic [6:0] RESET_CYCLE_R8   = 7'd0;
   localparam logic [8:0] RESET_LINE       = 9'd0;

   localparam logic [8:0] BADLINE_FIRST  = 9'd48;
   localparam logic [8:0] BADLINE_LAST   = 9'd247;
   localparam logic [8:0] DEN_LATCH_LINE = 9'd48;

   localparam logic [4:0] SPRITE_HEIGHT      = 5'd21;
   localparam logic [6:0] SPRITE_CHECK_CYCLE = 7'd55;
   localparam logic [6:0] LAST_G_CYCLE       = 7'd54;

   // High phi half types
   function automatic logic is_high_half(input logic [3:0] t);
      case (t)
         VIC_LP, VIC_LS2, VIC_LPI2, VIC_LR, VIC_LG, VIC_LI: return 1'b0;
         default: return 1'b1;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== verilog/phase_gen.sv ====
`default_nettype none

module phase_gen import vic_pkg::*; (
   input  wire        clk_dot4x,
   input  wire        rst,
   input  wire  [1:0] chip,
   output logic       clk_phi,
   output logic       phi_phase_start_0,
   output logic [6:0] cycle_num,
   output logic [8:0] raster_line,
   output logic       line_start
);

   logic [$clog2(PHASE_TICKS)-1:0] tick;
   logic [6:0] last_cycle;
   logic [8:0] last_line;
   logic [6:0] reset_cycle;

   // Line and frame limits of the selected revision
   always_comb begin
      case (chip)
         CHIP6567R8: begin
            last_cycle  = CYCLES_R8 - 7'd1;
            last_line   = LINES_R8 - 9'd1;
            reset_cycle = RESET_CYCLE_R8;
         end
         CHIP6567R56A: begin
            last_cycle  = CYCLES_R56A - 7'd1;
            last_line   = LINES_R56A - 9'd1;
            reset_cycle = RESET_CYCLE_R56A;
         end
         default: begin
            last_cycle  = CYCLES_6569 - 7'd1;
            last_line   = LINES_6569 - 9'd1;
            reset_cycle = RESET_CYCLE_6569;
         end
      endcase
   end

   // Last tick of the current half
   assign phi_phase_start_0 = (int'(tick) == PHASE_TICKS - 1);

   // Wrap happens as the high half of the last cycle ends
   assign line_start = phi_phase_start_0 & clk_phi & (cycle_num == last_cycle);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tick        <= '0;
         clk_phi     <= 1'b0;
         cycle_num   <= reset_cycle;
         raster_line <= RESET_LINE;
      end else if (phi_phase_start_0) begin
         tick    <= '0;
         clk_phi <= ~clk_phi;
         if (clk_phi) begin
            if (cycle_num == last_cycle) begin
               cycle_num   <= '0;
               raster_line <= (raster_line == last_line) ? '0 : raster_line + 9'd1;
            end else begin
               cycle_num <= cycle_num + 7'd1;
            end
         end
      end else begin
         tick <= tick + 1'b1;
      end
   end

   // Halves are several ticks long, so strobes never touch
   assert property (@(posedge clk_dot4x) disable iff (rst)
      phi_phase_start_0 |=> !phi_phase_start_0);

endmodule

`default_nettype wire

// ==== verilog/badline_detect.sv ====
`default_nettype none

module badline_detect import vic_pkg::*; (
   input  wire       clk_dot4x,
   input  wire       rst,
   input  wire [8:0] raster_line,
   input  wire [2:0] yscroll,
   input  wire       den,
   input  wire [6:0] cycle_num,
   input  wire       phi_phase_start_0,
   output logic      badline
);

   logic den_seen;
   logic in_window;
   logic den_ok;

   always_comb begin
      in_window = (raster_line >= BADLINE_FIRST) && (raster_line <= BADLINE_LAST);
      // DEN on the latch line itself already counts
      den_ok = den_seen || ((raster_line == DEN_LATCH_LINE) && den);
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         den_seen <= 1'b0;
         badline  <= 1'b0;
      end else if (phi_phase_start_0) begin
         if ((raster_line == DEN_LATCH_LINE) && den)
            den_seen <= 1'b1;
         else if (raster_line == RESET_LINE)
            den_seen <= 1'b0;
         // Decision held for the whole line
         if (cycle_num == 7'd0)
            badline <= in_window && (raster_line[2:0] == yscroll) && den_ok;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/sprite_dma_ctrl.sv ====
`default_nettype none

module sprite_dma_ctrl import vic_pkg::*; (
   input  wire                    clk_dot4x,
   input  wire                    rst,
   input  wire                    sprite_wr,
   input  wire  [2:0]             sprite_idx,
   input  wire  [7:0]             sprite_y,
   input  wire                    sprite_en,
   input  wire  [8:0]             raster_line,
   input  wire  [6:0]             cycle_num,
   input  wire                    phi_phase_start_0,
   output logic [NUM_SPRITES-1:0] sprite_dma
);

   logic [7:0]             spr_y [NUM_SPRITES];
   logic [NUM_SPRITES-1:0] spr_en;
   logic [4:0]             spr_left [NUM_SPRITES];
   logic                   check_done;
   logic                   check_now;

   // Both halves of the check cycle strobe; only the first one compares
   assign check_now = phi_phase_start_0 && (cycle_num == SPRITE_CHECK_CYCLE) && !check_done;

   always_ff @(posedge clk_dot4x) begin
      if (sprite_wr)
         spr_y[sprite_idx] <= sprite_y;
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         spr_en     <= '0;
         sprite_dma <= '0;
         check_done <= 1'b0;
      end else begin
         if (sprite_wr)
            spr_en[sprite_idx] <= sprite_en;

         if (check_now)
            check_done <= 1'b1;
         else if (cycle_num != SPRITE_CHECK_CYCLE)
            check_done <= 1'b0;

         if (check_now) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
               if (sprite_dma[i]) begin
                  if (spr_left[i] == 5'd1)
                     sprite_dma[i] <= 1'b0;
               end else if (spr_en[i] && (spr_y[i] == raster_line[7:0])) begin
                  sprite_dma[i] <= 1'b1;
               end
            end
         end
      end
   end

   // Lines left, reloaded while idle and counted down while active
   always_ff @(posedge clk_dot4x) begin
      if (check_now) begin
         for (int i = 0; i < NUM_SPRITES; i++) begin
            if (sprite_dma[i])
               spr_left[i] <= spr_left[i] - 5'd1;
            else
               spr_left[i] <= SPRITE_HEIGHT;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cycle_sequencer.sv ====
`default_nettype none

module cycle_sequencer import vic_pkg::*; (
   input  wire                   clk_dot4x,
   input  wire                   rst,
   input  wire                   clk_phi,
   input  wire [1:0]             chip,
   input  wire                   phi_phase_start_0,
   input  wire [NUM_SPRITES-1:0] sprite_dma,
   input  wire                   badline,
   input  wire [6:0]             cycle_num,
   output logic [3:0]            cycle_type,
   output logic [2:0]            sprite_cnt
);

   logic [2:0] refresh_cnt;
   logic [2:0] idle_cnt;

   // Sprite slot:  LP -dma-> HS1 LS2 HS3,  else HPI1 LPI2 HPI3
   // Refresh:      (LR HRI) x4, LR then HRC on a badline or HRX
   // Graphics:     LG HGC/HGI up to cycle 54, whose high half is HI
   // Idle:         LI HI until the revision's idle count is reached
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         // Line starts in sprite 3's slot; no DMA is active yet
         if (chip == CHIP6567R8) begin
            cycle_type <= VIC_LPI2;
            idle_cnt   <= 3'd4;
         end else begin
            cycle_type <= VIC_LP;
            idle_cnt   <= 3'd3;
         end
         sprite_cnt  <= 3'd3;
         refresh_cnt <= 3'd0;
      end else if (phi_phase_start_0) begin
         if (!clk_phi) begin
            // Low half ending
            case (cycle_type)
               VIC_LP: begin
                  if (sprite_dma[sprite_cnt])
                     cycle_type <= VIC_HS1;
                  else
                     cycle_type <= VIC_HPI1;
               end
               VIC_LS2:  cycle_type <= VIC_HS3;
               VIC_LPI2: cycle_type <= VIC_HPI3;
               VIC_LR: begin
                  if (refresh_cnt == 3'd4)
                     cycle_type <= badline ? VIC_HRC : VIC_HRX;
                  else
                     cycle_type <= VIC_HRI;
               end
               VIC_LG: begin
                  if (cycle_num == LAST_G_CYCLE) begin
                     cycle_type <= VIC_HI;
                     idle_cnt   <= 3'd0;
                  end else begin
                     cycle_type <= badline ? VIC_HGC : VIC_HGI;
                  end
               end
               VIC_LI:   cycle_type <= VIC_HI;
               default:  cycle_type <= cycle_type;
            endcase
         end else begin
            // High half ending
            case (cycle_type)
               VIC_HS1:  cycle_type <= VIC_LS2;
               VIC_HPI1: cycle_type <= VIC_LPI2;
               VIC_HS3, VIC_HPI3: begin
                  if (sprite_cnt == 3'd7) begin
                     // R8 spends its extra idle cycle here
                     cycle_type  <= (chip == CHIP6567R8) ? VIC_LI : VIC_LR;
                     sprite_cnt  <= 3'd0;
                     refresh_cnt <= 3'd0;
                  end else begin
                     cycle_type <= VIC_LP;
                     sprite_cnt <= sprite_cnt + 3'd1;
                  end
               end
               VIC_HRI: begin
                  cycle_type  <= VIC_LR;
                  refresh_cnt <= refresh_cnt + 3'd1;
               end
               VIC_HRC, VIC_HRX, VIC_HGC, VIC_HGI: cycle_type <= VIC_LG;
               VIC_HI: begin
                  if (chip == CHIP6567R56A && idle_cnt == 3'd3) begin
                     cycle_type <= VIC_LP;
                  end else if (chip == CHIP6567R8 && idle_cnt == 3'd3) begin
                     // Mark the deferred idle cycle as still owed
                     idle_cnt   <= idle_cnt + 3'd1;
                     cycle_type <= VIC_LP;
                  end else if (chip == CHIP6567R8 && idle_cnt == 3'd4) begin
                     cycle_type <= VIC_LR;
                  end else if (chip != CHIP6567R8 && chip != CHIP6567R56A &&
                               idle_cnt == 3'd2) begin
                     cycle_type <= VIC_LP;
                  end else begin
                     idle_cnt   <= idle_cnt + 3'd1;
                     cycle_type <= VIC_LI;
                  end
               end
               default: cycle_type <= cycle_type;
            endcase
         end
      end
   end

   assert property (@(posedge clk_dot4x) disable iff (rst) !$isunknown(cycle_type));

   // The new type belongs to the half that phase_gen has just entered
   assert property (@(posedge clk_dot4x) disable iff (rst)
      phi_phase_start_0 |=> (is_high_half(cycle_type) == !$past(clk_phi)));

endmodule

`default_nettype wire

// ==== verilog/access_decode.sv ====
`default_nettype none

module access_decode import vic_pkg::*; (
   input  wire        clk_dot4x,
   input  wire        rst,
   input  wire  [3:0] cycle_type,
   input  wire        phi_phase_start_0,
   output logic       acc_stb,
   output logic [2:0] acc_kind,
   output logic       ba
);

   logic [2:0] kind;
   logic       high_half;

   always_comb begin
      high_half = is_high_half(cycle_type);
      case (cycle_type)
         VIC_HS1, VIC_LS2, VIC_HS3:   kind = ACC_S;
         VIC_LP:                      kind = ACC_P;
         VIC_HPI1, VIC_LPI2, VIC_HPI3: kind = ACC_I;
         // Fifth refresh finishes in the high half, whatever the branch
         VIC_LR, VIC_HRI, VIC_HRC, VIC_HRX: kind = ACC_R;
         VIC_HGC:                     kind = ACC_C;
         VIC_LG:                      kind = ACC_G;
         default:                     kind = ACC_I;
      endcase
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         acc_stb <= 1'b0;
         ba      <= 1'b1;
      end else begin
         acc_stb <= phi_phase_start_0;
         if (phi_phase_start_0)
            ba <= !(high_half && (kind == ACC_C || kind == ACC_S));
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (phi_phase_start_0)
         acc_kind <= kind;
   end

endmodule

`default_nettype wire

// ==== verilog/vic_cycle_top.sv ====
`default_nettype none

module vic_cycle_top import vic_pkg::*; (
   input  wire        clk_dot4x,
   input  wire        rst,
   input  wire  [1:0] chip,
   input  wire  [2:0] yscroll,
   input  wire        den,
   input  wire        sprite_wr,
   input  wire  [2:0] sprite_idx,
   input  wire  [7:0] sprite_y,
   input  wire        sprite_en,
   output logic       acc_stb,
   output logic [2:0] acc_kind,
   output logic       ba,
   output logic       line_start,
   output logic [8:0] raster_line
);

   logic                   clk_phi;
   logic                   phi_phase_start_0;
   logic [6:0]             cycle_num;
   logic                   badline;
   logic [NUM_SPRITES-1:0] sprite_dma;
   logic [3:0]             cycle_type;
   logic [2:0]             sprite_cnt;

   phase_gen u_phase_gen (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .chip              (chip),
      .clk_phi           (clk_phi),
      .phi_phase_start_0 (phi_phase_start_0),
      .cycle_num         (cycle_num),
      .raster_line       (raster_line),
      .line_start        (line_start)
   );

   badline_detect u_badline_detect (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .raster_line       (raster_line),
      .yscroll           (yscroll),
      .den               (den),
      .cycle_num         (cycle_num),
      .phi_phase_start_0 (phi_phase_start_0),
      .badline           (badline)
   );

   sprite_dma_ctrl u_sprite_dma_ctrl (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .sprite_wr         (sprite_wr),
      .sprite_idx        (sprite_idx),
      .sprite_y          (sprite_y),
      .sprite_en         (sprite_en),
      .raster_line       (raster_line),
      .cycle_num         (cycle_num),
      .phi_phase_start_0 (phi_phase_start_0),
      .sprite_dma        (sprite_dma)
   );

   cycle_sequencer u_cycle_sequencer (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .clk_phi           (clk_phi),
      .chip              (chip),
      .phi_phase_start_0 (phi_phase_start_0),
      .sprite_dma        (sprite_dma),
      .badline           (badline),
      .cycle_num         (cycle_num),
      .cycle_type        (cycle_type),
      .sprite_cnt        (sprite_cnt)
   );

   access_decode u_access_decode (
      .clk_dot4x         (clk_dot4x),
      .rst               (rst),
      .cycle_type        (cycle_type),
      .phi_phase_start_0 (phi_phase_start_0),
      .acc_stb           (acc_stb),
      .acc_kind          (acc_kind),
      .ba                (ba)
   );

endmodule

`default_nettype wire

// ==== verif/tb_vic_cycle.sv ====
`default_nettype none

module tb_vic_cycle import vic_pkg::*; ();

   logic       clk_dot4x;
   logic       rst;
   logic [1:0] chip;
   logic [2:0] yscroll;
   logic       den;
   logic       sprite_wr;
   logic [2:0] sprite_idx;
   logic [7:0] sprite_y;
   logic       sprite_en;
   logic       acc_stb;
   logic [2:0] acc_kind;
   logic       ba;
   logic       line_start;
   logic [8:0] raster_line;

   logic [15:0] stim [0:255];
   int          errors;
   int          lines_checked;
   int          cyc_count;
   int          cyc_limit;

   // Access counters of the line in progress
   int   cnt_kind [0:7];
   int   cnt_total;
   int   cnt_balow;
   logic in_reset;
   logic seen_stb;
   logic line_pend;
   logic skip_line;

   // Reference model state
   logic [8:0] m_line;
   logic [1:0] m_chip;
   logic [2:0] m_ysc;
   logic       m_den;
   logic [7:0] m_y [0:7];
   logic [7:0] m_en;
   logic [7:0] dma_prev;
   int         m_left [0:7];

   vic_cycle_top UUT (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .chip        (chip),
      .yscroll     (yscroll),
      .den         (den),
      .sprite_wr   (sprite_wr),
      .sprite_idx  (sprite_idx),
      .sprite_y    (sprite_y),
      .sprite_en   (sprite_en),
      .acc_stb     (acc_stb),
      .acc_kind    (acc_kind),
      .ba          (ba),
      .line_start  (line_start),
      .raster_line (raster_line)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #5 clk_dot4x = ~clk_dot4x;
   end

   function automatic int cycles_per_line(input logic [1:0] c);
      case (c)
         CHIP6567R8:   return 65;
         CHIP6567R56A: return 64;
         default:      return 63;
      endcase
   endfunction

   function automatic int lines_per_frame(input logic [1:0] c);
      case (c)
         CHIP6567R8:   return 263;
         CHIP6567R56A: return 262;
         default:      return 312;
      endcase
   endfunction

   function automatic logic is_badline(input logic [8:0] l);
      return m_den && (l >= BADLINE_FIRST) && (l <= BADLINE_LAST) && (l[2:0] == m_ysc);
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s at line %0d: got 0x%0h, expected 0x%0h", name, m_line, got, exp);
      end
   endtask

   task automatic clear_counts();
      for (int k = 0; k < 8; k++)
         cnt_kind[k] = 0;
      cnt_total = 0;
      cnt_balow = 0;
   endtask

   // Y compare of the line that is ending, DMA runs SPRITE_HEIGHT lines
   task automatic update_sprites(output logic [7:0] cur);
      for (int i = 0; i < 8; i++) begin
         if (dma_prev[i]) begin
            m_left[i] = m_left[i] - 1;
            cur[i] = (m_left[i] > 0);
         end else if (m_en[i] && (m_y[i] == m_line[7:0])) begin
            m_left[i] = SPRITE_HEIGHT;
            cur[i] = 1'b1;
         end else begin
            cur[i] = 1'b0;
         end
      end
   endtask

   task automatic close_line();
      logic [7:0] cur;
      logic       bad;
      int         exp_s;
      int         exp_hi;
      int         exp_c;
      int         exp_g;
      int         exp_total;
      bad = is_badline(m_line);
      update_sprites(cur);
      exp_s  = 0;
      exp_hi = 0;
      // Sprites 0-2 follow this line's compare, 3-7 the previous one
      for (int i = 0; i < 8; i++) begin
         if (i == 3 && m_chip == CHIP6567R8) begin
            // R8 splits slot 3 over the line boundary
            if (dma_prev[3]) begin
               exp_s  += 2;
               exp_hi += 1;
            end
            if (cur[3]) begin
               exp_s  += 1;
               exp_hi += 1;
            end
         end else if ((i < 3) ? cur[i] : dma_prev[i]) begin
            exp_s  += 3;
            exp_hi += 2;
         end
      end
      // Graphics in cycles 15 to 54, c-accesses in high halves 15 to 53
      exp_g     = LAST_G_CYCLE - 15 + 1;
      exp_c     = bad ? (LAST_G_CYCLE - 15) : 0;
      exp_total = 2 * cycles_per_line(m_chip);
      if (skip_line) begin
         skip_line = 1'b0;
      end else begin
         check_value("acc_stb count", cnt_total, exp_total);
         check_value("acc_kind ACC_P count", cnt_kind[ACC_P], 8);
         check_value("acc_kind ACC_S count", cnt_kind[ACC_S], exp_s);
         check_value("acc_kind ACC_R count", cnt_kind[ACC_R], 10);
         check_value("acc_kind ACC_C count", cnt_kind[ACC_C], exp_c);
         check_value("acc_kind ACC_G count", cnt_kind[ACC_G], exp_g);
         check_value("acc_kind ACC_I count", cnt_kind[ACC_I],
                     exp_total - 18 - exp_s - exp_c - exp_g);
         check_value("ba low count", cnt_balow, exp_c + exp_hi);
         lines_checked++;
      end
      dma_prev = cur;
      m_line = (int'(m_line) == lines_per_frame(m_chip) - 1) ? 9'd0 : m_line + 9'd1;
      check_value("raster_line", raster_line, m_line);
      clear_counts();
   endtask

   // One clock, sampled at the falling edge
   task automatic step_clock();
      @(negedge clk_dot4x);
      cyc_count++;
      if (cyc_count > cyc_limit) begin
         $display("ERROR: timeout, the stimulus did not finish within %0d clocks", cyc_limit);
         $display("Verification failed");
         $finish;
      end
      if (in_reset) begin
         check_value("acc_stb", acc_stb, 0);
         check_value("ba", ba, 1);
      end else begin
         if (!seen_stb)
            check_value("ba", ba, 1);
         if (acc_stb) begin
            seen_stb = 1'b1;
            cnt_kind[acc_kind]++;
            cnt_total++;
            if (!ba)
               cnt_balow++;
            // Last half of a line reports one clock after line_start
            if (line_pend) begin
               line_pend = 1'b0;
               close_line();
            end
         end
         if (line_start)
            line_pend = 1'b1;
      end
   endtask

   task automatic apply_reset(input logic [1:0] c, input logic [2:0] ys, input logic d);
      rst       = 1'b1;
      chip      = c;
      yscroll   = ys;
      den       = d;
      in_reset  = 1'b1;
      repeat (10) step_clock();
      rst       = 1'b0;
      in_reset  = 1'b0;
      m_chip    = c;
      m_ysc     = ys;
      m_den     = d;
      m_line    = RESET_LINE;
      m_en      = '0;
      dma_prev  = '0;
      for (int i = 0; i < 8; i++)
         m_left[i] = 0;
      seen_stb  = 1'b0;
      line_pend = 1'b0;
      skip_line = 1'b1;
      clear_counts();
   endtask

   task automatic write_sprite(input logic [2:0] idx, input logic [7:0] y, input logic en);
      sprite_wr  = 1'b1;
      sprite_idx = idx;
      sprite_y   = y;
      sprite_en  = en;
      step_clock();
      sprite_wr  = 1'b0;
      m_y[idx]   = y;
      m_en[idx]  = en;
   endtask

   task automatic run_lines(input int n);
      int target;
      target = lines_checked + n;
      while (lines_checked < target)
         step_clock();
   endtask

   initial begin
      int pc;
      int line_sum;
      int resets;
      rst        = 1'b1;
      chip       = CHIP6569;
      yscroll    = 3'd0;
      den        = 1'b0;
      sprite_wr  = 1'b0;
      sprite_idx = 3'd0;
      sprite_y   = 8'd0;
      sprite_en  = 1'b0;
      errors        = 0;
      lines_checked = 0;
      cyc_count     = 0;
      in_reset      = 1'b1;
      seen_stb      = 1'b0;
      line_pend     = 1'b0;
      skip_line     = 1'b1;
      m_line        = RESET_LINE;
      clear_counts();

      for (int k = 0; k < 256; k++)
         stim[k] = '0;
      $readmemh("verif/vic_cycle_stim.txt", stim);

      // Budget: every line at the longest chip, plus reset and skipped line
      line_sum = 0;
      resets   = 0;
      for (int k = 0; k < 256; k += 4) begin
         if (stim[k] == 16'd3)
            line_sum += stim[k+1];
         else if (stim[k] == 16'd1)
            resets++;
      end
      cyc_limit = line_sum * 65 * 8 + resets * (10 + 65 * 8) + 2000;
      if (resets == 0) begin
         errors++;
         $display("ERROR: no reset record found in the stimulus file");
      end

      pc = 0;
      while (pc < 256 && stim[pc] != 16'd0) begin
         case (stim[pc])
            16'd1: apply_reset(stim[pc+1][1:0], stim[pc+2][2:0], stim[pc+3][0]);
            16'd2: write_sprite(stim[pc+1][2:0], stim[pc+2][7:0], stim[pc+3][0]);
            16'd3: run_lines(stim[pc+1]);
            default: begin
               errors++;
               $display("ERROR: unknown stimulus record type %0h", stim[pc]);
               pc = 256;
            end
         endcase
         pc += 4;
      end

      $display("Checked %0d lines in %0d clocks, %0d errors", lines_checked, cyc_count, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/vic_cycle_stim.txt ====
// Columns (hex): op arg0 arg1 arg2
// op 1 reset: chip yscroll den | op 2 sprite write: idx y en | op 3 run lines: n | op 0 end
1 1 3 1
2 0 32 1
2 3 34 1
2 5 40 0
2 7 3c 1
3 60 0 0
1 2 0 0
2 2 05 1
2 6 0a 1
3 110 0 0
1 0 7 1
2 3 30 1
2 4 31 1
2 1 2f 1
3 50 0 0
2 0 5a 1
2 4 5e 1
3 20 0 0
0 0 0 0

// ==== project.f ====
verilog/vic_pkg.sv
verilog/phase_gen.sv
verilog/badline_detect.sv
verilog/sprite_dma_ctrl.sv
verilog/cycle_sequencer.sv
verilog/access_decode.sv
verilog/vic_cycle_top.sv
verif/tb_vic_cycle.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the VIC-II cycle testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_vic_cycle \
   -f project.f -o tb_vic_cycle
./obj_dir/tb_vic_cycle > sim.log 2>&1 || true
cat sim.log
if grep -q "^Verification passed$" sim.log; then
   exit 0
else
   exit 1
fi
